//--- rv_pkg.sv
package rv_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [63:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // branch compare kinds
    typedef enum logic [2:0] {
        cmp_eq,
        cmp_ne,
        cmp_lt,
        cmp_ge,
        cmp_ltu,
        cmp_geu
    } cmp_op_e;

    // write-back source where link means pc+4
    typedef enum logic [1:0] {
        wb_alu,
        wb_imm,
        wb_link
    } wb_sel_e;

    typedef enum logic [1:0] {
        fs_boot,
        fs_request,
        fs_wait_rsp
    } fetch_state_e;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     rd_we;
        xlen_t    imm;
        alu_op_e  alu_op;
        logic     src_a_pc;
        logic     src_b_imm;
        logic     is_branch;
        cmp_op_e  cmp_op;
        logic     is_jump;
        wb_sel_e  wb_sel;
    } decoded_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        inst_t inst;
    } fetch_rsp_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        inst_t    inst;
        logic     rd_we;
        reg_idx_t rd;
        xlen_t    rd_data;
    } commit_t;

endpackage

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter rv_pkg::addr_t reset_vector = 64'h0000_0000_8000_0000
) (
    input  logic               inst_selfdefine,
    input  logic               reset,
    output rv_pkg::fetch_req_t fetch_req,
    input  rv_pkg::fetch_rsp_t fetch_rsp,
    output rv_pkg::addr_t      pc,
    input  rv_pkg::decoded_t   dec,
    input  rv_pkg::xlen_t      alu_result,
    input  logic               branch_taken
);

    rv_pkg::fetch_state_e state;
    rv_pkg::addr_t        next_pc;

    // alu already holds pc+imm for branches and the target for jumps
    always_comb begin
        if (dec.is_jump) begin
            next_pc = {alu_result[63:1], 1'b0};
        end else if (branch_taken) begin
            next_pc = alu_result;
        end else begin
            next_pc = pc + 64'd4;
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state <= rv_pkg::fs_boot;
            pc    <= reset_vector;
        end else begin
            case (state)
                rv_pkg::fs_boot: begin
                    state <= rv_pkg::fs_request;
                end
                rv_pkg::fs_request: begin
                    state <= rv_pkg::fs_wait_rsp;
                end
                rv_pkg::fs_wait_rsp: begin
                    if (fetch_rsp.valid) begin
                        state <= rv_pkg::fs_request;
                        pc    <= next_pc;
                    end
                end
                default: begin
                    state <= rv_pkg::fs_boot;
                end
            endcase
        end
    end

    // one strobe per instruction
    assign fetch_req.valid = (state == rv_pkg::fs_request);
    assign fetch_req.addr  = pc;

endmodule

//--- decoder.sv
`timescale 1ns/1ps

module decoder (
    input  rv_pkg::inst_t    inst,
    output rv_pkg::decoded_t dec
);

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    rv_pkg::xlen_t   imm_i;
    rv_pkg::xlen_t   imm_u;
    rv_pkg::xlen_t   imm_j;
    rv_pkg::xlen_t   imm_b;
    rv_pkg::alu_op_e arith_op;
    logic            rd_write;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // OP and OP-IMM share this map and only OP has sub
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == op_reg && inst[30]) ? rv_pkg::alu_sub
                                                                : rv_pkg::alu_add;
            3'b001:  arith_op = rv_pkg::alu_sll;
            3'b010:  arith_op = rv_pkg::alu_slt;
            3'b011:  arith_op = rv_pkg::alu_sltu;
            3'b100:  arith_op = rv_pkg::alu_xor;
            3'b101:  arith_op = inst[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  arith_op = rv_pkg::alu_or;
            default: arith_op = rv_pkg::alu_and;
        endcase
    end

    always_comb begin
        dec           = '0;
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.rd        = inst[11:7];
        dec.alu_op    = rv_pkg::alu_add;
        dec.cmp_op    = rv_pkg::cmp_eq;
        dec.wb_sel    = rv_pkg::wb_alu;
        rd_write      = 1'b0;
        case (opcode)
            op_reg: begin
                dec.alu_op = arith_op;
                rd_write   = 1'b1;
            end
            op_imm: begin
                dec.alu_op    = arith_op;
                dec.imm       = imm_i;
                dec.src_b_imm = 1'b1;
                rd_write      = 1'b1;
            end
            op_lui: begin
                dec.imm    = imm_u;
                dec.wb_sel = rv_pkg::wb_imm;
                rd_write   = 1'b1;
            end
            op_auipc: begin
                dec.imm       = imm_u;
                dec.src_a_pc  = 1'b1;
                dec.src_b_imm = 1'b1;
                rd_write      = 1'b1;
            end
            op_jal: begin
                dec.imm       = imm_j;
                dec.src_a_pc  = 1'b1;
                dec.src_b_imm = 1'b1;
                dec.is_jump   = 1'b1;
                dec.wb_sel    = rv_pkg::wb_link;
                rd_write      = 1'b1;
            end
            op_jalr: begin
                dec.imm       = imm_i;
                dec.src_b_imm = 1'b1;
                dec.is_jump   = 1'b1;
                dec.wb_sel    = rv_pkg::wb_link;
                rd_write      = 1'b1;
            end
            op_branch: begin
                dec.imm       = imm_b;
                dec.src_a_pc  = 1'b1;
                dec.src_b_imm = 1'b1;
                // funct3 010 and 011 are reserved and fall through as a no-op
                dec.is_branch = (funct3[2:1] != 2'b01);
                case (funct3)
                    3'b001:  dec.cmp_op = rv_pkg::cmp_ne;
                    3'b100:  dec.cmp_op = rv_pkg::cmp_lt;
                    3'b101:  dec.cmp_op = rv_pkg::cmp_ge;
                    3'b110:  dec.cmp_op = rv_pkg::cmp_ltu;
                    3'b111:  dec.cmp_op = rv_pkg::cmp_geu;
                    default: dec.cmp_op = rv_pkg::cmp_eq;
                endcase
            end
            default: begin
                rd_write = 1'b0;
            end
        endcase
        dec.rd_we = rd_write && (dec.rd != 5'd0);
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic             inst_selfdefine,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::xlen_t    rs1_data,
    output rv_pkg::xlen_t    rs2_data,
    input  logic             rd_we,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::xlen_t    rd_data
);

    // x0 has no storage
    rv_pkg::xlen_t regs [1:31];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    always_comb begin
        if (rs1 == 5'd0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == 5'd0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::addr_t    pc,
    input  rv_pkg::xlen_t    rs1_data,
    input  rv_pkg::xlen_t    rs2_data,
    output rv_pkg::xlen_t    alu_result,
    output logic             branch_taken
);

    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    logic [5:0]    shamt;
    logic          rs_eq;
    logic          rs_lt;
    logic          rs_ltu;
    logic          cmp_hit;

    assign op_a  = dec.src_a_pc ? pc : rs1_data;
    assign op_b  = dec.src_b_imm ? dec.imm : rs2_data;
    assign shamt = op_b[5:0];

    always_comb begin
        case (dec.alu_op)
            rv_pkg::alu_add: begin
                alu_result = op_a + op_b;
            end
            rv_pkg::alu_sub: begin
                alu_result = op_a - op_b;
            end
            rv_pkg::alu_sll: begin
                alu_result = op_a << shamt;
            end
            rv_pkg::alu_slt: begin
                alu_result = {63'd0, $signed(op_a) < $signed(op_b)};
            end
            rv_pkg::alu_sltu: begin
                alu_result = {63'd0, op_a < op_b};
            end
            rv_pkg::alu_xor: begin
                alu_result = op_a ^ op_b;
            end
            rv_pkg::alu_srl: begin
                alu_result = op_a >> shamt;
            end
            rv_pkg::alu_sra: begin
                alu_result = $signed(op_a) >>> shamt;
            end
            rv_pkg::alu_or: begin
                alu_result = op_a | op_b;
            end
            default: begin
                alu_result = op_a & op_b;
            end
        endcase
    end

    // branches compare the two registers rather than the alu operands
    assign rs_eq  = (rs1_data == rs2_data);
    assign rs_lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign rs_ltu = (rs1_data < rs2_data);

    always_comb begin
        case (dec.cmp_op)
            rv_pkg::cmp_eq:  cmp_hit = rs_eq;
            rv_pkg::cmp_ne:  cmp_hit = !rs_eq;
            rv_pkg::cmp_lt:  cmp_hit = rs_lt;
            rv_pkg::cmp_ge:  cmp_hit = !rs_lt;
            rv_pkg::cmp_ltu: cmp_hit = rs_ltu;
            rv_pkg::cmp_geu: cmp_hit = !rs_ltu;
            default:         cmp_hit = 1'b0;
        endcase
    end

    assign branch_taken = dec.is_branch && cmp_hit;

endmodule

//--- retire_unit.sv
`timescale 1ns/1ps

module retire_unit (
    input  logic               inst_selfdefine,
    input  logic               reset,
    input  rv_pkg::fetch_rsp_t fetch_rsp,
    input  rv_pkg::addr_t      pc,
    input  rv_pkg::decoded_t   dec,
    input  rv_pkg::xlen_t      alu_result,
    output logic               rd_we,
    output rv_pkg::reg_idx_t   rd,
    output rv_pkg::xlen_t      rd_data,
    output rv_pkg::commit_t    commit
);

    always_comb begin
        case (dec.wb_sel)
            rv_pkg::wb_imm:  rd_data = dec.imm;
            rv_pkg::wb_link: rd_data = pc + 64'd4;
            default:         rd_data = alu_result;
        endcase
    end

    // only a live instruction may write
    assign rd_we = fetch_rsp.valid && dec.rd_we;
    assign rd    = dec.rd;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            commit <= '0;
        end else begin
            commit.valid <= fetch_rsp.valid;
            if (fetch_rsp.valid) begin
                commit.pc      <= pc;
                commit.inst    <= fetch_rsp.inst;
                commit.rd_we   <= rd_we;
                commit.rd      <= rd;
                commit.rd_data <= rd_data;
            end
        end
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::addr_t reset_vector = 64'h0000_0000_8000_0000
) (
    input  logic               inst_selfdefine,
    input  logic               reset,
    output rv_pkg::fetch_req_t fetch_req,
    input  rv_pkg::fetch_rsp_t fetch_rsp,
    output rv_pkg::commit_t    commit
);

    rv_pkg::addr_t    pc;
    rv_pkg::decoded_t dec;
    rv_pkg::xlen_t    rs1_data;
    rv_pkg::xlen_t    rs2_data;
    rv_pkg::xlen_t    alu_result;
    logic             branch_taken;
    logic             wb_we;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::xlen_t    wb_data;

    fetch_unit #(
        .reset_vector(reset_vector)
    ) u_fetch (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .fetch_req      (fetch_req),
        .fetch_rsp      (fetch_rsp),
        .pc             (pc),
        .dec            (dec),
        .alu_result     (alu_result),
        .branch_taken   (branch_taken)
    );

    // instruction word is only meaningful while the response strobe is high
    decoder u_decoder (
        .inst(fetch_rsp.inst),
        .dec (dec)
    );

    regfile u_regfile (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .rs1            (dec.rs1),
        .rs2            (dec.rs2),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .rd_we          (wb_we),
        .rd             (wb_rd),
        .rd_data        (wb_data)
    );

    exec_unit u_exec (
        .dec         (dec),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .branch_taken(branch_taken)
    );

    retire_unit u_retire (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .fetch_rsp      (fetch_rsp),
        .pc             (pc),
        .dec            (dec),
        .alu_result     (alu_result),
        .rd_we          (wb_we),
        .rd             (wb_rd),
        .rd_data        (wb_data),
        .commit         (commit)
    );

endmodule

//--- tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// architectural state of the reference model
rv_pkg::addr_t model_pc;
rv_pkg::xlen_t model_regs [0:31];

task automatic reset_model(input rv_pkg::addr_t start_pc);
    model_pc = start_pc;
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
endtask

// alt selects sub for funct3 000 and sra for funct3 101
function automatic rv_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                          input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[5:0];
        3'd2:    return {63'd0, $signed(a) < $signed(b)};
        3'd3:    return {63'd0, a < b};
        3'd4:    return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[5:0];
            end
            return a >> b[5:0];
        end
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic rv_pkg::inst_t random_inst();
    logic [31:0] r;
    logic [31:0] f;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [6:0]  op;
    r     = $random(seed);
    f     = $random(seed);
    f3    = r[14:12];
    imm12 = f[11:0];
    // steer some writes to x0
    if (f[31:29] == 3'd0) begin
        r[11:7] = 5'd0;
    end
    case (r[31:28])
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
            return {1'b0, f[0] && (f3 == 3'd0 || f3 == 3'd5), 5'd0, r[24:7], 7'h33};
        end
        4'd5, 4'd6, 4'd7, 4'd8: begin
            // shifts keep a 6 bit shamt and srai sets bit 30
            if (f3 == 3'd1) begin
                imm12[11:6] = 6'd0;
            end else if (f3 == 3'd5) begin
                imm12[11:6] = {1'b0, f[0], 4'd0};
            end
            return {imm12, r[19:7], 7'h13};
        end
        4'd9:    return {f[19:0], r[11:7], 7'h37};
        4'd10:   return {f[19:0], r[11:7], 7'h17};
        4'd11:   return {f[19:0], r[11:7], 7'h6f};
        4'd12:   return {imm12, r[19:15], 3'd0, r[11:7], 7'h67};
        4'd13, 4'd14: begin
            if (f3[2:1] == 2'b01) begin
                f3[2] = 1'b1;
            end
            return {f[6:0], r[24:15], f3, f[11:7], 7'h63};
        end
        default: begin
            op = f[6:0];
            while (op inside {7'h33, 7'h13, 7'h37, 7'h17, 7'h6f, 7'h67, 7'h63}) begin
                op = op + 7'd1;
            end
            return {r[31:7], op};
        end
    endcase
endfunction

task automatic predict_step(input rv_pkg::inst_t inst, output rv_pkg::commit_t exp);
    rv_pkg::xlen_t a;
    rv_pkg::xlen_t b;
    rv_pkg::xlen_t imm_i;
    rv_pkg::xlen_t imm_u;
    rv_pkg::xlen_t imm_j;
    rv_pkg::xlen_t imm_b;
    rv_pkg::xlen_t data;
    rv_pkg::addr_t next;
    logic          we;
    logic          take;
    a     = model_regs[inst[19:15]];
    b     = model_regs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    data  = '0;
    next  = model_pc + 64'd4;
    we    = 1'b1;
    case (inst[6:0])
        7'h33: data = alu_ref(inst[14:12], inst[30], a, b);
        7'h13: data = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
        7'h37: data = imm_u;
        7'h17: data = model_pc + imm_u;
        7'h6f: begin
            data = model_pc + 64'd4;
            next = (model_pc + imm_j) & ~64'd1;
        end
        7'h67: begin
            data = model_pc + 64'd4;
            next = (a + imm_i) & ~64'd1;
        end
        7'h63: begin
            we = 1'b0;
            case (inst[14:12])
                3'd0:    take = (a == b);
                3'd1:    take = (a != b);
                3'd4:    take = ($signed(a) < $signed(b));
                3'd5:    take = ($signed(a) >= $signed(b));
                3'd6:    take = (a < b);
                3'd7:    take = (a >= b);
                default: take = 1'b0;
            endcase
            if (take) begin
                next = model_pc + imm_b;
            end
        end
        default: we = 1'b0;
    endcase
    we  = we && (inst[11:7] != 5'd0);
    exp = {1'b1, model_pc, inst, we, inst[11:7], data};
    if (we) begin
        model_regs[inst[11:7]] = data;
    end
    model_pc = next;
endtask

`endif

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam rv_pkg::addr_t reset_vector = 64'h0000_0000_8000_0000;
    localparam int            n_inst       = 200;
    // a request cycle plus up to four wait cycles per instruction
    localparam int            cycle_limit  = n_inst * 6 + 50;

    logic               inst_selfdefine;
    logic               reset;
    rv_pkg::fetch_req_t fetch_req;
    rv_pkg::fetch_rsp_t fetch_rsp;
    rv_pkg::commit_t    commit;

    integer          seed = 27979;
    int              pass_count = 0;
    int              fail_count = 0;
    int              cycles = 0;
    int              retired = 0;
    int              issued = 0;
    int              delay_left = 0;
    logic            waiting = 1'b0;
    logic            rsp_active = 1'b0;
    logic            expect_commit = 1'b0;
    logic            seen_req = 1'b0;
    logic            timed_out = 1'b0;
    rv_pkg::commit_t exp_commit;
    rv_pkg::inst_t   next_inst;
    logic [31:0]     rnd;
    string           exp_name;

    `include "tb_rv_model.svh"

    rv_core #(
        .reset_vector(reset_vector)
    ) uut (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .fetch_req      (fetch_req),
        .fetch_rsp      (fetch_rsp),
        .commit         (commit)
    );

    initial begin
        inst_selfdefine = 1'b0;
        forever #4 inst_selfdefine = ~inst_selfdefine;
    end

    function automatic string commit_text(input rv_pkg::commit_t c);
        return $sformatf("pc %h inst %h we %b rd %0d data %h",
                         c.pc, c.inst, c.rd_we, c.rd, c.rd_data);
    endfunction

    task automatic fail_check(input string msg);
        $display("ERROR %s", msg);
        fail_count++;
    endtask

    task automatic check_commit(input string name, input rv_pkg::commit_t exp,
                                input rv_pkg::commit_t act);
        rv_pkg::commit_t e;
        rv_pkg::commit_t a;
        e = exp;
        a = act;
        // rd_data carries nothing without a write
        if (!e.rd_we) begin
            e.rd_data = '0;
            a.rd_data = '0;
        end
        if (a !== e) begin
            $display("MISMATCH %s expected %s actual %s", name, commit_text(exp),
                     commit_text(act));
            fail_count++;
        end else begin
            $display("PASS %s %s", name, commit_text(act));
            pass_count++;
        end
    endtask

    task automatic check_fetch_addr(input string name, input rv_pkg::addr_t exp,
                                    input rv_pkg::addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_count++;
        end else begin
            $display("PASS %s addr %h", name, act);
            pass_count++;
        end
    endtask

    task automatic check_strobes_low(input string name);
        if (fetch_req.valid !== 1'b0 || commit.valid !== 1'b0) begin
            fail_check($sformatf("%s: fetch or commit strobe is high", name));
        end else begin
            $display("PASS %s", name);
            pass_count++;
        end
    endtask

    initial begin
        reset     = 1'b1;
        fetch_rsp = '0;
        reset_model(reset_vector);
        @(posedge inst_selfdefine);
        @(negedge inst_selfdefine);
        check_strobes_low("strobes during reset");
        @(posedge inst_selfdefine);
        reset <= 1'b0;
        @(negedge inst_selfdefine);
        check_strobes_low("strobes after reset");
        while (retired < n_inst && !timed_out) begin
            @(negedge inst_selfdefine);
            cycles++;
            if (cycles > cycle_limit) begin
                fail_check($sformatf("timeout after %0d cycles, %0d of %0d retired",
                                     cycles, retired, n_inst));
                timed_out = 1'b1;
            end else begin
                if (commit.valid !== expect_commit) begin
                    fail_check($sformatf("commit strobe was %b in cycle %0d, expected %b",
                                         commit.valid, cycles, expect_commit));
                end else if (expect_commit) begin
                    check_commit(exp_name, exp_commit, commit);
                    retired++;
                end
                if (fetch_req.valid === 1'b1) begin
                    if (waiting || rsp_active) begin
                        fail_check("fetch request issued while a response was pending");
                    end else begin
                        if (seen_req && !expect_commit) begin
                            fail_check("fetch request without a preceding response");
                        end
                        check_fetch_addr($sformatf("fetch %0d", issued), model_pc,
                                         fetch_req.addr);
                        seen_req   = 1'b1;
                        waiting    = 1'b1;
                        rnd        = $random(seed);
                        delay_left = 1 + int'(rnd[1:0]);
                    end
                end else if (expect_commit) begin
                    fail_check("no fetch request in the cycle after a response");
                end
                expect_commit = rsp_active;
            end
            @(posedge inst_selfdefine);
            rnd        = $random(seed);
            rsp_active = 1'b0;
            if (waiting) begin
                delay_left--;
            end
            if (waiting && delay_left == 0) begin
                next_inst = random_inst();
                exp_name  = $sformatf("commit %0d opcode %h", issued, next_inst[6:0]);
                predict_step(next_inst, exp_commit);
                fetch_rsp <= {1'b1, next_inst};
                waiting    = 1'b0;
                rsp_active = 1'b1;
                issued++;
            end else begin
                // idle bus carries junk the core must ignore
                fetch_rsp <= {1'b0, rnd};
            end
        end
        $display("summary: %0d checks passed, %0d failed, %0d of %0d instructions retired",
                 pass_count, fail_count, retired, n_inst);
        if (fail_count == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
rv_pkg.sv
fetch_unit.sv
decoder.sv
regfile.sv
exec_unit.sv
retire_unit.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
